// ==== verilog/memCtrlPkg.sv ====
package memCtrlPkg;

    // one RAM byte and one full word
    typedef logic [7:0] byteT;
    typedef logic [31:0] wordT;

    // access length in bytes from 0 to 4
    typedef logic [2:0] lenT;

    typedef enum logic {
        Load  = 1'b0,
        Store = 1'b1
    } lsT;

    // current job of the controller
    typedef enum logic [1:0] {
        Idle      = 2'd0,
        ReadInst  = 2'd1,
        ReadData  = 2'd2,
        WriteData = 2'd3
    } reqKindT;

    // bytes in an instruction fetch
    localparam int BytesPerWord = 4;

endpackage

// ==== verilog/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter import memCtrlPkg::*; #(
    parameter int addrWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioBufferFull,
    input  logic                 i_infEn,
    input  logic [addrWidth-1:0] i_infAddr,
    output logic                 o_infDone,
    output wordT                 o_infInst,
    input  logic                 i_dcEn,
    input  lsT                   i_dcLs,
    input  lenT                  i_dcLen,
    input  wordT                 i_dcDt,
    input  logic [addrWidth-1:0] i_dcAddr,
    output logic                 o_dcDone,
    output wordT                 o_dcDt,
    output logic                 o_start,
    output reqKindT              o_kind,
    output logic [addrWidth-1:0] o_addr,
    output lenT                  o_len,
    output wordT                 o_wdata,
    output logic                 o_step,
    input  logic                 i_finish,
    input  wordT                 i_rword
);
    reqKindT kind;

    // pause when RAM not ready or the io buffer is full
    assign o_step = i_rdy && !i_ioBufferFull;

    // accept only from idle with the data cache first
    assign o_start = (kind == Idle) && o_step && (i_dcEn || i_infEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            kind <= Idle;
        end else if (o_start) begin
            if (i_dcEn) begin
                kind <= (i_dcLs == Store) ? WriteData : ReadData;
            end else begin
                kind <= ReadInst;
            end
        end else if (i_finish) begin
            kind <= Idle;
        end
    end

    // a fetch always latches a full word
    always_ff @(posedge clk) begin
        if (o_start) begin
            if (i_dcEn) begin
                o_addr  <= i_dcAddr;
                o_len   <= i_dcLen;
                o_wdata <= i_dcDt;
            end else begin
                o_addr <= i_infAddr;
                o_len  <= lenT'(BytesPerWord);
            end
        end
    end

    assign o_kind = kind;

    // completion goes back to whoever owns the job
    assign o_infDone = i_finish && (kind == ReadInst);
    assign o_dcDone  = i_finish && (kind == ReadData || kind == WriteData);
    assign o_infInst = o_infDone ? i_rword : '0;
    assign o_dcDt    = (o_dcDone && kind == ReadData) ? i_rword : '0;

    // the sequencer never completes during a pause
    assert property (@(posedge clk) disable iff (rst) !o_step |-> !i_finish);

    // a data request moves one to four bytes
    assert property (@(posedge clk) disable iff (rst)
        (o_start && i_dcEn) |-> (i_dcLen != '0 && i_dcLen <= lenT'(BytesPerWord)));

endmodule

// ==== verilog/byteSequencer.sv ====
`timescale 1ns/100ps

module byteSequencer import memCtrlPkg::*; #(
    parameter int addrWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  reqKindT              i_kind,
    input  logic [addrWidth-1:0] i_addr,
    input  lenT                  i_len,
    input  wordT                 i_wdata,
    input  logic                 i_step,
    input  byteT                 i_memDt,
    output logic                 o_memRw,
    output logic [addrWidth-1:0] o_memAddr,
    output byteT                 o_memDt,
    output logic                 o_finish,
    output wordT                 o_rword
);
    lenT  issueCnt;
    lenT  capCnt;
    lenT  offset;
    wordT rdata;
    logic isRead;
    logic isWrite;
    logic holdAddr;
    logic doIssue;
    logic doCapture;

    assign isRead  = (i_kind == ReadInst) || (i_kind == ReadData);
    assign isWrite = (i_kind == WriteData);

    assign doIssue   = i_step && (isRead || isWrite) && (issueCnt < i_len);
    assign doCapture = i_step && isRead && (capCnt < issueCnt);

    // keep the last issued address while paused or once all bytes are out,
    // so the pending read byte stays valid
    assign holdAddr  = (issueCnt != '0) && (!i_step || issueCnt == i_len);
    assign offset    = holdAddr ? issueCnt - lenT'(1) : issueCnt;
    assign o_memAddr = i_addr + addrWidth'(offset);

    // store data goes out least significant byte first
    assign o_memRw = doIssue && isWrite;
    assign o_memDt = i_wdata[8*issueCnt[1:0] +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt <= '0;
            capCnt   <= '0;
        end else if (i_start) begin
            issueCnt <= '0;
            capCnt   <= '0;
        end else begin
            if (doIssue) begin
                issueCnt <= issueCnt + lenT'(1);
            end
            if (doCapture) begin
                capCnt <= capCnt + lenT'(1);
            end
        end
    end

    // cleared on start, so unused upper bytes read as zero
    always_ff @(posedge clk) begin
        if (i_start) begin
            rdata <= '0;
        end else if (doCapture) begin
            rdata[8*capCnt[1:0] +: 8] <= i_memDt;
        end
    end

    // last read byte is merged straight from the RAM bus
    assign o_rword = rdata | (wordT'(i_memDt) << (8 * capCnt[1:0]));

    always_comb begin
        if (!i_step) begin
            o_finish = 1'b0;
        end else if (isRead) begin
            o_finish = (issueCnt == i_len) && (capCnt == i_len - lenT'(1));
        end else if (isWrite) begin
            o_finish = (issueCnt == i_len - lenT'(1));
        end else begin
            o_finish = 1'b0;
        end
    end

    // finish is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) o_finish |=> !o_finish);

    // capture never runs ahead of issue
    assert property (@(posedge clk) disable iff (rst)
        (issueCnt <= lenT'(BytesPerWord)) && (capCnt <= issueCnt));

endmodule

// ==== verilog/memCtrl.sv ====
`timescale 1ns/100ps

module memCtrl import memCtrlPkg::*; #(
    parameter int addrWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioBufferFull,
    input  byteT                 i_memDt,
    output logic                 o_memRw,
    output logic [addrWidth-1:0] o_memAddr,
    output byteT                 o_memDt,
    input  logic                 i_infEn,
    input  logic [addrWidth-1:0] i_infAddr,
    output logic                 o_infDone,
    output wordT                 o_infInst,
    input  logic                 i_dcEn,
    input  lsT                   i_dcLs,
    input  lenT                  i_dcLen,
    input  wordT                 i_dcDt,
    input  logic [addrWidth-1:0] i_dcAddr,
    output logic                 o_dcDone,
    output wordT                 o_dcDt
);
    logic                 start;
    reqKindT              kind;
    logic [addrWidth-1:0] addr;
    lenT                  len;
    wordT                 wdata;
    logic                 step;
    logic                 finish;
    wordT                 rword;

    memArbiter #(.addrWidth(addrWidth)) u_arbiter (
        .clk(clk), .rst(rst),
        .i_rdy(i_rdy), .i_ioBufferFull(i_ioBufferFull),
        .i_infEn(i_infEn), .i_infAddr(i_infAddr),
        .o_infDone(o_infDone), .o_infInst(o_infInst),
        .i_dcEn(i_dcEn), .i_dcLs(i_dcLs), .i_dcLen(i_dcLen),
        .i_dcDt(i_dcDt), .i_dcAddr(i_dcAddr),
        .o_dcDone(o_dcDone), .o_dcDt(o_dcDt),
        .o_start(start), .o_kind(kind), .o_addr(addr), .o_len(len),
        .o_wdata(wdata), .o_step(step),
        .i_finish(finish), .i_rword(rword)
    );

    byteSequencer #(.addrWidth(addrWidth)) u_sequencer (
        .clk(clk), .rst(rst),
        .i_start(start), .i_kind(kind), .i_addr(addr), .i_len(len),
        .i_wdata(wdata), .i_step(step), .i_memDt(i_memDt),
        .o_memRw(o_memRw), .o_memAddr(o_memAddr), .o_memDt(o_memDt),
        .o_finish(finish), .o_rword(rword)
    );

endmodule

// ==== tests/ramModel.sv ====
`timescale 1ns/100ps

module ramModel import memCtrlPkg::*; #(
    parameter int addrWidth = 17
) (
    input  logic                 clk,
    input  logic                 i_rw,
    input  logic [addrWidth-1:0] i_addr,
    input  byteT                 i_wdata,
    output byteT                 o_rdata,
    output int                   o_writeCount
);
    byteT mem [0:(1 << addrWidth) - 1];
    byteT rdata = '0;
    int   writes = 0;

    // every address byte is folded into the fill value
    function automatic byteT fillByte(int a);
        byteT v;
        v = 8'h5A;
        for (int i = 0; i < addrWidth; i += 8) begin
            v = v ^ byteT'(a >> i);
        end
        return v;
    endfunction

    initial begin
        for (int a = 0; a < (1 << addrWidth); a++) begin
            mem[addrWidth'(a)] = fillByte(a);
        end
    end

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        if (i_rw) begin
            mem[i_addr] <= i_wdata;
            writes <= writes + 1;
        end
        rdata <= mem[i_addr];
    end

    assign o_rdata      = rdata;
    assign o_writeCount = writes;

endmodule

// ==== tests/memCtrlTb.sv ====
`timescale 1ns/100ps

module memCtrlTb import memCtrlPkg::*; ();
    localparam int AddrW = 17;
    localparam int CyclesPerEntry = 40;
    localparam int WhoFetch = 0;
    localparam int WhoData = 1;
    localparam int WhoBoth = 2;

    typedef struct packed {
        int   who;
        lsT   ls;
        int   addr;
        int   len;
        wordT wdata;
        int   fetchAddr;
        logic pause;
        wordT expDc;
        wordT expInf;
    } entryT;

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic             rdy = 1'b1;
    logic             ioBufFull = 1'b0;
    byteT             memRdata;
    logic             memRw;
    logic [AddrW-1:0] memAddr;
    byteT             memWdata;
    logic             infEn = 1'b0;
    logic [AddrW-1:0] infAddr = '0;
    logic             infDone;
    wordT             infInst;
    logic             dcEn = 1'b0;
    lsT               dcLs = Load;
    lenT              dcLen = '0;
    wordT             dcDt = '0;
    logic [AddrW-1:0] dcAddr = '0;
    logic             dcDone;
    wordT             dcRdata;
    int               writeCount;

    entryT stimTab [$];
    byteT  shadow [int];
    int    seed = 5989;
    logic  pauseOn = 1'b0;
    int    cycleCnt = 0;
    int    cycleLimit = 0;
    int    checkErrs = 0;
    int    pauseErrs = 0;

    memCtrl #(.addrWidth(AddrW)) u_dut (
        .clk(clk), .rst(rst),
        .i_rdy(rdy), .i_ioBufferFull(ioBufFull),
        .i_memDt(memRdata), .o_memRw(memRw), .o_memAddr(memAddr), .o_memDt(memWdata),
        .i_infEn(infEn), .i_infAddr(infAddr), .o_infDone(infDone), .o_infInst(infInst),
        .i_dcEn(dcEn), .i_dcLs(dcLs), .i_dcLen(dcLen), .i_dcDt(dcDt), .i_dcAddr(dcAddr),
        .o_dcDone(dcDone), .o_dcDt(dcRdata)
    );

    ramModel #(.addrWidth(AddrW)) u_ram (
        .clk(clk), .i_rw(memRw), .i_addr(memAddr), .i_wdata(memWdata),
        .o_rdata(memRdata), .o_writeCount(writeCount)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // random stalls only while the current entry asks for them
    always @(posedge clk) begin
        if (rst || !pauseOn) begin
            rdy <= 1'b1;
            ioBufFull <= 1'b0;
        end else begin
            rdy <= ({$random(seed)} % 4) != 0;
            ioBufFull <= ({$random(seed)} % 6) == 0;
        end
    end

    always @(negedge clk) begin
        if (!rst && (!rdy || ioBufFull)) begin
            assert (!dcDone && !infDone) else begin
                $display("ERROR %0t: a done output was high while the controller was paused",
                    $time);
                pauseErrs++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt > cycleLimit) begin
            $display("ERROR %0t: run did not finish within %0d cycles", $time, cycleLimit);
            $display("errors: %0d result, %0d pause, 1 timeout", checkErrs, pauseErrs);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // initial RAM byte from 5A and every address byte
    function automatic byteT initByte(int a);
        byteT v;
        v = 8'h5A;
        for (int i = 0; i < AddrW; i += 8) begin
            v = v ^ byteT'(a >> i);
        end
        return v;
    endfunction

    function automatic wordT readWord(int a, int len);
        wordT w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[8*i +: 8] = shadow.exists(a + i) ? shadow[a + i] : initByte(a + i);
        end
        return w;
    endfunction

    task automatic storeBytes(int a, int len, wordT d);
        for (int i = 0; i < len; i++) begin
            shadow[a + i] = d[8*i +: 8];
        end
    endtask

    task automatic addEntry(int who, lsT ls, int addr, int len, wordT wdata,
                            int fetchAddr, logic pause);
        entryT e;
        e.who = who;
        e.ls = ls;
        e.addr = addr;
        e.len = len;
        e.wdata = wdata;
        e.fetchAddr = fetchAddr;
        e.pause = pause;
        e.expDc = '0;
        e.expInf = '0;
        stimTab.push_back(e);
    endtask

    task automatic buildTable();
        // who, load/store, addr, len, store data, fetch addr, pause
        addEntry(WhoFetch, Load,  0,       4, '0,           'h00100, 1'b0);
        addEntry(WhoFetch, Load,  0,       4, '0,           'h1F3F2, 1'b0);
        addEntry(WhoData,  Load,  'h00203, 1, '0,           0,       1'b0);
        addEntry(WhoData,  Load,  'h00455, 2, '0,           0,       1'b0);
        addEntry(WhoData,  Load,  'h10010, 4, '0,           0,       1'b0);
        addEntry(WhoData,  Store, 'h00300, 1, 32'hDEADBEEF, 0,       1'b0);
        addEntry(WhoData,  Load,  'h00300, 4, '0,           0,       1'b0);
        addEntry(WhoData,  Store, 'h00304, 2, 32'h12345678, 0,       1'b0);
        addEntry(WhoData,  Load,  'h00303, 4, '0,           0,       1'b0);
        addEntry(WhoData,  Store, 'h00308, 4, 32'hCAFEF00D, 0,       1'b0);
        addEntry(WhoData,  Load,  'h00308, 4, '0,           0,       1'b0);
        addEntry(WhoBoth,  Load,  'h00500, 2, '0,           'h00600, 1'b0);
        addEntry(WhoBoth,  Store, 'h00600, 4, 32'hA5A5C3C3, 'h00600, 1'b0);
        addEntry(WhoFetch, Load,  0,       4, '0,           'h00700, 1'b1);
        addEntry(WhoData,  Load,  'h00304, 1, '0,           0,       1'b1);
        addEntry(WhoData,  Store, 'h00702, 2, 32'h0000BEEF, 0,       1'b1);
        addEntry(WhoData,  Load,  'h00700, 4, '0,           0,       1'b1);
        addEntry(WhoData,  Store, 'h00709, 1, 32'h00000077, 0,       1'b1);
        addEntry(WhoBoth,  Load,  'h00708, 4, '0,           'h00300, 1'b1);
        addEntry(WhoBoth,  Store, 'h12344, 4, 32'h0BADCAFE, 'h12344, 1'b1);
        addEntry(WhoData,  Load,  'h12345, 4, '0,           0,       1'b0);
    endtask

    // data side runs first, so its store is seen by the fetch of the same entry
    task automatic fillExpected();
        entryT e;
        for (int k = 0; k < stimTab.size(); k++) begin
            e = stimTab[k];
            if (e.who != WhoFetch) begin
                if (e.ls == Store) begin
                    storeBytes(e.addr, e.len, e.wdata);
                end else begin
                    e.expDc = readWord(e.addr, e.len);
                end
            end
            if (e.who != WhoData) begin
                e.expInf = readWord(e.fetchAddr, BytesPerWord);
            end
            stimTab[k] = e;
        end
    endtask

    task automatic runEntry(input entryT e);
        int   cyc;
        int   dcAt;
        int   infAt;
        int   wrBefore;
        int   dcLat;
        int   infLat;
        int   expWrites;
        logic needDc;
        logic needInf;
        cyc = 0;
        dcAt = -1;
        infAt = -1;
        wrBefore = 0;
        needDc = (e.who != WhoFetch);
        needInf = (e.who != WhoData);
        dcLat = (e.ls == Store) ? e.len : e.len + 1;
        // fetch behind a data job starts in the idle cycle after its done
        infLat = (e.who == WhoBoth) ? dcLat + BytesPerWord + 2 : BytesPerWord + 1;
        expWrites = (needDc && e.ls == Store) ? e.len : 0;
        pauseOn <= e.pause;
        @(posedge clk);
        if (needDc) begin
            dcEn <= 1'b1;
            dcLs <= e.ls;
            dcLen <= lenT'(e.len);
            dcDt <= e.wdata;
            dcAddr <= AddrW'(e.addr);
        end
        if (needInf) begin
            infEn <= 1'b1;
            infAddr <= AddrW'(e.fetchAddr);
        end
        while (needDc || needInf) begin
            @(negedge clk);
            if (cyc == 0) begin
                wrBefore = writeCount;
            end
            if (needDc && dcDone) begin
                dcAt = cyc;
                needDc = 1'b0;
                if (e.ls == Load) begin
                    assert (dcRdata === e.expDc) else begin
                        $display("FAILED %0t o_dcDt expected %h got %h", $time, e.expDc, dcRdata);
                        checkErrs++;
                    end
                end
            end
            if (needInf && infDone) begin
                infAt = cyc;
                needInf = 1'b0;
                assert (infInst === e.expInf) else begin
                    $display("FAILED %0t o_infInst expected %h got %h", $time, e.expInf, infInst);
                    checkErrs++;
                end
            end
            @(posedge clk);
            if (!needDc) begin
                dcEn <= 1'b0;
            end
            if (!needInf) begin
                infEn <= 1'b0;
            end
            cyc++;
        end
        @(negedge clk);
        assert (writeCount - wrBefore == expWrites) else begin
            $display("FAILED %0t RAM write count expected %0d got %0d", $time, expWrites,
                writeCount - wrBefore);
            checkErrs++;
        end
        if (!e.pause && e.who != WhoFetch) begin
            assert (dcAt == dcLat) else begin
                $display("FAILED %0t o_dcDone latency expected %0d got %0d", $time, dcLat, dcAt);
                checkErrs++;
            end
        end
        if (!e.pause && e.who != WhoData) begin
            assert (infAt == infLat) else begin
                $display("FAILED %0t o_infDone latency expected %0d got %0d", $time, infLat,
                    infAt);
                checkErrs++;
            end
        end
        if (e.who == WhoBoth) begin
            assert (dcAt < infAt) else begin
                $display("ERROR %0t: fetch finished before the data cache request", $time);
                checkErrs++;
            end
        end
    endtask

    initial begin
        buildTable();
        fillExpected();
        cycleLimit = CyclesPerEntry * stimTab.size();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < stimTab.size(); k++) begin
            runEntry(stimTab[k]);
        end
        $display("errors: %0d result, %0d pause, 0 timeout", checkErrs, pauseErrs);
        if (checkErrs == 0 && pauseErrs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== memCtrl.f ====
verilog/memCtrlPkg.sv
verilog/memArbiter.sv
verilog/byteSequencer.sv
verilog/memCtrl.sv
tests/ramModel.sv
tests/memCtrlTb.sv

// ==== Makefile ====
TOP = memCtrlTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module memCtrl -f memCtrl.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f memCtrl.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
